/* hw/biu_macros.svh */
`ifndef BIU_MACROS_SVH
`define BIU_MACROS_SVH

// Bus field widths
`define BIU_ADDR_W 40
`define BIU_DATA_W 128
`define BIU_STRB_W 16
`define BIU_ID_W 5

// AR/R ID reserved for instruction fetch
`define BIU_IFU_ID 5'h1f

// Per-channel limit on transactions in flight
`define BIU_MAX_OUTSTANDING 4

// Quiet cycles before no-op rises
`define BIU_IDLE_HOLD 2

`endif

/* hw/biu_pkg.sv */
`include "biu_macros.svh"

package biu_pkg;

  // AR request, shared by ifu and lsu
  typedef struct packed {
    logic [`BIU_ADDR_W-1:0] addr;
    logic [`BIU_ID_W-1:0]   id;
    logic [1:0]             len;
    logic [2:0]             size;
  } rd_req_t;

  // One R beat
  typedef struct packed {
    logic [`BIU_DATA_W-1:0] data;
    logic [`BIU_ID_W-1:0]   id;
    logic [3:0]             resp;
    logic                   last;
  } rd_beat_t;

  // Single-beat write, AW and W fields together
  typedef struct packed {
    logic [`BIU_ADDR_W-1:0] addr;
    logic [`BIU_ID_W-1:0]   id;
    logic [2:0]             size;
    logic [`BIU_DATA_W-1:0] data;
    logic [`BIU_STRB_W-1:0] strb;
  } wr_req_t;

  typedef struct packed {
    logic [`BIU_ID_W-1:0] id;
    logic [1:0]           resp;
  } b_resp_t;

  typedef enum logic {
    CH_IDLE,
    CH_ISSUE
  } ch_state_e;

  typedef enum logic {
    WR_ST,
    WR_VICT
  } wr_src_e;

  typedef enum logic [1:0] {
    IDLE_ACTIVE,
    IDLE_COUNT,
    IDLE_QUIET
  } idle_state_e;

endpackage

/* hw/biu_read_channel.sv */
`timescale 1ns/1ns
`include "biu_macros.svh"

module biu_read_channel (
  input  logic               coreclk,
  input  logic               rst_n,
  input  logic               ifu_rd_req,
  input  biu_pkg::rd_req_t   ifu_rd,
  input  logic               lsu_ar_req,
  input  biu_pkg::rd_req_t   lsu_ar,
  input  logic               pad_arready,
  input  logic               pad_rvalid,
  input  biu_pkg::rd_beat_t  pad_r,
  input  logic               ifu_r_ready,
  input  logic               lsu_r_ready,
  output logic               ifu_rd_grnt,
  output logic               lsu_ar_grnt,
  output logic               pad_arvalid,
  output biu_pkg::rd_req_t   pad_ar,
  output logic               pad_rready,
  output logic               ifu_rd_vld,
  output logic               lsu_r_vld,
  output biu_pkg::rd_beat_t  r_beat,
  output logic               read_busy
);
  import biu_pkg::*;

  localparam int CNT_W = $clog2(`BIU_MAX_OUTSTANDING + 1);

  ch_state_e         state_q;
  rd_req_t           ar_q;
  rd_req_t           ifu_req;
  logic [CNT_W-1:0]  cnt_q;
  logic              can_grant;
  logic              ar_done;
  logic              r_done;
  logic              r_to_ifu;

  // Fetch traffic always goes out with the reserved ID
  always_comb begin
    ifu_req    = ifu_rd;
    ifu_req.id = `BIU_IFU_ID;
  end

  assign can_grant   = (state_q == CH_IDLE) && (cnt_q < CNT_W'(`BIU_MAX_OUTSTANDING));
  assign lsu_ar_grnt = lsu_ar_req & can_grant;
  assign ifu_rd_grnt = ifu_rd_req & ~lsu_ar_req & can_grant;

  assign pad_arvalid = (state_q == CH_ISSUE);
  assign pad_ar      = ar_q;
  assign ar_done     = pad_arvalid & pad_arready;

  always_ff @(posedge coreclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= CH_IDLE;
    end else if (lsu_ar_grnt || ifu_rd_grnt) begin
      state_q <= CH_ISSUE;
    end else if (ar_done) begin
      state_q <= CH_IDLE;
    end
  end

  always_ff @(posedge coreclk) begin
    if (lsu_ar_grnt) begin
      ar_q <= lsu_ar;
    end else if (ifu_rd_grnt) begin
      ar_q <= ifu_req;
    end
  end

  // R steering by ID
  assign r_to_ifu   = (pad_r.id == `BIU_IFU_ID);
  assign pad_rready = r_to_ifu ? ifu_r_ready : lsu_r_ready;
  assign ifu_rd_vld = pad_rvalid & r_to_ifu;
  assign lsu_r_vld  = pad_rvalid & ~r_to_ifu;
  assign r_beat     = pad_r;
  assign r_done     = pad_rvalid & pad_rready & pad_r.last;

  always_ff @(posedge coreclk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      case ({ar_done, r_done})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  assign read_busy = (state_q == CH_ISSUE) || (cnt_q != '0);

  a_ar_stable: assert property (@(posedge coreclk) disable iff (!rst_n)
    pad_arvalid && !pad_arready |=> pad_arvalid && $stable(pad_ar));

  a_cnt_limit: assert property (@(posedge coreclk) disable iff (!rst_n)
    cnt_q <= CNT_W'(`BIU_MAX_OUTSTANDING));

  // The fetch ID must never show up on a load request
  a_lsu_id: assert property (@(posedge coreclk) disable iff (!rst_n)
    lsu_ar_req |-> lsu_ar.id != `BIU_IFU_ID);

endmodule

/* hw/biu_write_channel.sv */
`timescale 1ns/1ns
`include "biu_macros.svh"

module biu_write_channel (
  input  logic              coreclk,
  input  logic              rst_n,
  input  logic              st_req,
  input  biu_pkg::wr_req_t  st,
  input  logic              vict_req,
  input  biu_pkg::wr_req_t  vict,
  input  logic              pad_awready,
  input  logic              pad_wready,
  input  logic              pad_bvalid,
  input  biu_pkg::b_resp_t  pad_b,
  output logic              st_grnt,
  output logic              vict_grnt,
  output logic              pad_awvalid,
  output logic              pad_wvalid,
  output biu_pkg::wr_req_t  pad_wr,
  output logic              lsu_b_vld,
  output biu_pkg::b_resp_t  lsu_b,
  output logic              write_busy
);
  import biu_pkg::*;

  localparam int CNT_W = $clog2(`BIU_MAX_OUTSTANDING + 1);

  ch_state_e         state_q;
  wr_src_e           src_q;
  wr_req_t           wr_q;
  logic              aw_pend_q;
  logic              w_pend_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              can_grant;
  logic              aw_done;
  logic              w_done;
  logic              issue_done;

  assign can_grant = (state_q == CH_IDLE) && (cnt_q < CNT_W'(`BIU_MAX_OUTSTANDING));
  assign vict_grnt = vict_req & can_grant;
  assign st_grnt   = st_req & ~vict_req & can_grant;

  assign pad_awvalid = aw_pend_q;
  assign pad_wvalid  = w_pend_q;
  assign pad_wr      = wr_q;

  assign aw_done = aw_pend_q & pad_awready;
  assign w_done  = w_pend_q & pad_wready;
  // Both beats gone, either earlier or in this cycle
  assign issue_done = (~aw_pend_q | pad_awready) & (~w_pend_q | pad_wready);

  always_ff @(posedge coreclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= CH_IDLE;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
    end else if (vict_grnt || st_grnt) begin
      state_q   <= CH_ISSUE;
      aw_pend_q <= 1'b1;
      w_pend_q  <= 1'b1;
    end else if (state_q == CH_ISSUE) begin
      if (aw_done) begin
        aw_pend_q <= 1'b0;
      end
      if (w_done) begin
        w_pend_q <= 1'b0;
      end
      if (issue_done) begin
        state_q <= CH_IDLE;
      end
    end
  end

  always_ff @(posedge coreclk) begin
    if (vict_grnt) begin
      wr_q  <= vict;
      src_q <= WR_VICT;
    end else if (st_grnt) begin
      wr_q  <= st;
      src_q <= WR_ST;
    end
  end

  // B always accepted
  assign lsu_b_vld = pad_bvalid;
  assign lsu_b     = pad_b;

  always_ff @(posedge coreclk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      case ({aw_done, pad_bvalid})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  assign write_busy = (state_q == CH_ISSUE) || (cnt_q != '0);

  a_src_hold: assert property (@(posedge coreclk) disable iff (!rst_n)
    (state_q == CH_ISSUE) && !issue_done |=>
      (state_q == CH_ISSUE) && $stable(src_q) && $stable(wr_q));

  // A response with nothing in flight means the slave is confused
  a_b_no_orphan: assert property (@(posedge coreclk) disable iff (!rst_n)
    pad_bvalid |-> cnt_q != '0);

endmodule

/* hw/biu_idle_monitor.sv */
`timescale 1ns/1ns
`include "biu_macros.svh"

module biu_idle_monitor (
  input  logic coreclk,
  input  logic rst_n,
  input  logic read_busy,
  input  logic write_busy,
  output logic no_op
);
  import biu_pkg::*;

  localparam int HOLD_W = $clog2(`BIU_IDLE_HOLD + 1);

  idle_state_e        state_q;
  logic [HOLD_W-1:0]  hold_q;
  logic               busy;

  assign busy = read_busy | write_busy;

  always_ff @(posedge coreclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE_ACTIVE;
      hold_q  <= '0;
    end else if (busy) begin
      state_q <= IDLE_ACTIVE;
      hold_q  <= '0;
    end else begin
      case (state_q)
        IDLE_ACTIVE: begin
          state_q <= IDLE_COUNT;
          hold_q  <= HOLD_W'(1);
        end
        IDLE_COUNT: begin
          if (hold_q == HOLD_W'(`BIU_IDLE_HOLD)) begin
            state_q <= IDLE_QUIET;
          end else begin
            hold_q <= hold_q + 1'b1;
          end
        end
        default: state_q <= IDLE_QUIET;
      endcase
    end
  end

  assign no_op = (state_q == IDLE_QUIET);

endmodule

/* hw/biu_top.sv */
`timescale 1ns/1ns

module biu_top (
  input  logic               coreclk,
  input  logic               rst_n,
  input  logic               ifu_rd_req,
  input  biu_pkg::rd_req_t   ifu_rd,
  input  logic               lsu_ar_req,
  input  biu_pkg::rd_req_t   lsu_ar,
  input  logic               pad_arready,
  input  logic               pad_rvalid,
  input  biu_pkg::rd_beat_t  pad_r,
  input  logic               ifu_r_ready,
  input  logic               lsu_r_ready,
  input  logic               st_req,
  input  biu_pkg::wr_req_t   st,
  input  logic               vict_req,
  input  biu_pkg::wr_req_t   vict,
  input  logic               pad_awready,
  input  logic               pad_wready,
  input  logic               pad_bvalid,
  input  biu_pkg::b_resp_t   pad_b,
  output logic               ifu_rd_grnt,
  output logic               lsu_ar_grnt,
  output logic               pad_arvalid,
  output biu_pkg::rd_req_t   pad_ar,
  output logic               pad_rready,
  output logic               ifu_rd_vld,
  output logic               lsu_r_vld,
  output biu_pkg::rd_beat_t  r_beat,
  output logic               st_grnt,
  output logic               vict_grnt,
  output logic               pad_awvalid,
  output logic               pad_wvalid,
  output biu_pkg::wr_req_t   pad_wr,
  output logic               lsu_b_vld,
  output biu_pkg::b_resp_t   lsu_b,
  output logic               biu_no_op
);

  logic read_busy;
  logic write_busy;

  biu_read_channel u_read (
    .coreclk     (coreclk),
    .rst_n       (rst_n),
    .ifu_rd_req  (ifu_rd_req),
    .ifu_rd      (ifu_rd),
    .lsu_ar_req  (lsu_ar_req),
    .lsu_ar      (lsu_ar),
    .pad_arready (pad_arready),
    .pad_rvalid  (pad_rvalid),
    .pad_r       (pad_r),
    .ifu_r_ready (ifu_r_ready),
    .lsu_r_ready (lsu_r_ready),
    .ifu_rd_grnt (ifu_rd_grnt),
    .lsu_ar_grnt (lsu_ar_grnt),
    .pad_arvalid (pad_arvalid),
    .pad_ar      (pad_ar),
    .pad_rready  (pad_rready),
    .ifu_rd_vld  (ifu_rd_vld),
    .lsu_r_vld   (lsu_r_vld),
    .r_beat      (r_beat),
    .read_busy   (read_busy)
  );

  biu_write_channel u_write (
    .coreclk     (coreclk),
    .rst_n       (rst_n),
    .st_req      (st_req),
    .st          (st),
    .vict_req    (vict_req),
    .vict        (vict),
    .pad_awready (pad_awready),
    .pad_wready  (pad_wready),
    .pad_bvalid  (pad_bvalid),
    .pad_b       (pad_b),
    .st_grnt     (st_grnt),
    .vict_grnt   (vict_grnt),
    .pad_awvalid (pad_awvalid),
    .pad_wvalid  (pad_wvalid),
    .pad_wr      (pad_wr),
    .lsu_b_vld   (lsu_b_vld),
    .lsu_b       (lsu_b),
    .write_busy  (write_busy)
  );

  biu_idle_monitor u_idle (
    .coreclk    (coreclk),
    .rst_n      (rst_n),
    .read_busy  (read_busy),
    .write_busy (write_busy),
    .no_op      (biu_no_op)
  );

endmodule

/* verification/biu_tb.sv */
`timescale 1ns/1ns
`include "biu_macros.svh"

module biu_tb;
  import biu_pkg::*;

  localparam int CLK_NS   = 4;
  localparam int NUM_VEC  = 6;
  localparam int GRNT_MAX = 20;

  // kind 0 read pair, 1 write pair, 2 read outstanding limit
  // a is ifu or st, b is lsu or vict
  typedef struct packed {
    logic [1:0]           kind;
    logic                 req_a;
    logic                 req_b;
    logic                 first_b;
    logic [`BIU_ID_W-1:0] id;
    logic [1:0]           resp;
    logic [3:0]           dly_a;
    logic [3:0]           dly_b;
    logic [3:0]           hold;
  } vec_t;

  logic      coreclk;
  logic      rst_n;
  logic      ifu_rd_req;
  rd_req_t   ifu_rd;
  logic      lsu_ar_req;
  rd_req_t   lsu_ar;
  logic      pad_arready;
  logic      pad_rvalid;
  rd_beat_t  pad_r;
  logic      ifu_r_ready;
  logic      lsu_r_ready;
  logic      st_req;
  wr_req_t   st;
  logic      vict_req;
  wr_req_t   vict;
  logic      pad_awready;
  logic      pad_wready;
  logic      pad_bvalid;
  b_resp_t   pad_b;
  logic      ifu_rd_grnt;
  logic      lsu_ar_grnt;
  logic      pad_arvalid;
  rd_req_t   pad_ar;
  logic      pad_rready;
  logic      ifu_rd_vld;
  logic      lsu_r_vld;
  rd_beat_t  r_beat;
  logic      st_grnt;
  logic      vict_grnt;
  logic      pad_awvalid;
  logic      pad_wvalid;
  wr_req_t   pad_wr;
  logic      lsu_b_vld;
  b_resp_t   lsu_b;
  logic      biu_no_op;

  vec_t   vecs [NUM_VEC];
  integer seed;
  int     val_errs;
  int     hs_errs;

  biu_top u_biu_top (.*);

  initial begin
    coreclk = 1'b0;
    forever #(CLK_NS / 2) coreclk = ~coreclk;
  end

  task automatic advance();
    @(posedge coreclk);
    #1;
  endtask

  task automatic check_val(input string name, input logic [255:0] act,
                           input logic [255:0] exp);
    assert (act === exp) else begin
      val_errs++;
      $display("FAILED %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  function automatic logic [127:0] rand128();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic rd_req_t rand_rd();
    rd_req_t      r;
    logic [127:0] w;
    w      = rand128();
    r.addr = w[`BIU_ADDR_W-1:0];
    r.id   = w[100 +: `BIU_ID_W];
    r.len  = 2'd0;
    r.size = w[120 +: 3];
    return r;
  endfunction

  function automatic wr_req_t rand_wr();
    wr_req_t      r;
    logic [127:0] w;
    w      = rand128();
    r.addr = w[`BIU_ADDR_W-1:0];
    r.id   = w[64 +: `BIU_ID_W];
    r.size = 3'd4;
    r.data = rand128();
    r.strb = w[80 +: `BIU_STRB_W];
    return r;
  endfunction

  // Returns at the negedge of the cycle that carries a grant
  task automatic wait_grant(input bit rd);
    int   n;
    logic seen;
    n = 0;
    @(negedge coreclk);
    seen = rd ? (ifu_rd_grnt | lsu_ar_grnt) : (st_grnt | vict_grnt);
    while (!seen && n < GRNT_MAX) begin
      @(negedge coreclk);
      n++;
      seen = rd ? (ifu_rd_grnt | lsu_ar_grnt) : (st_grnt | vict_grnt);
    end
    assert (seen) else begin
      hs_errs++;
      $display("No %s grant arrived within %0d cycles at %0t", rd ? "read" : "write",
               GRNT_MAX, $time);
    end
  endtask

  task automatic check_ar(input rd_req_t exp);
    check_val("pad_arvalid", pad_arvalid, 1'b1);
    check_val("pad_ar", pad_ar, exp);
    check_val("lsu_ar_grnt", lsu_ar_grnt, 1'b0);
    check_val("ifu_rd_grnt", ifu_rd_grnt, 1'b0);
  endtask

  // Called at the negedge of the grant cycle
  task automatic issue_ar(input rd_req_t exp, input logic is_ifu, input int dly);
    check_val("pad_arvalid", pad_arvalid, 1'b0);
    advance();
    if (is_ifu) begin
      ifu_rd_req = 1'b0;
    end else begin
      lsu_ar_req = 1'b0;
    end
    repeat (dly) begin
      @(negedge coreclk);
      check_ar(exp);
      advance();
    end
    pad_arready = 1'b1;
    @(negedge coreclk);
    check_ar(exp);
    advance();
    pad_arready = 1'b0;
  endtask

  task automatic check_beat(input rd_beat_t b, input logic to_ifu, input logic rdy);
    check_val("ifu_rd_vld", ifu_rd_vld, to_ifu);
    check_val("lsu_r_vld", lsu_r_vld, !to_ifu);
    check_val("r_beat", r_beat, b);
    check_val("pad_rready", pad_rready, rdy);
    check_val("pad_arvalid", pad_arvalid, 1'b0);
    check_val("biu_no_op", biu_no_op, 1'b0);
  endtask

  // Only the wrong target is ready during the hold cycles
  task automatic return_beat(input logic [`BIU_ID_W-1:0] id, input int hold,
                             input logic to_ifu);
    rd_beat_t b;
    b.data      = rand128();
    b.id        = id;
    b.resp      = b.data[127:124];
    b.last      = 1'b1;
    pad_r       = b;
    pad_rvalid  = 1'b1;
    ifu_r_ready = !to_ifu;
    lsu_r_ready = to_ifu;
    repeat (hold) begin
      @(negedge coreclk);
      check_beat(b, to_ifu, 1'b0);
      advance();
    end
    ifu_r_ready = to_ifu;
    lsu_r_ready = !to_ifu;
    @(negedge coreclk);
    check_beat(b, to_ifu, 1'b1);
    advance();
    pad_rvalid  = 1'b0;
    ifu_r_ready = 1'b0;
    lsu_r_ready = 1'b0;
  endtask

  // no_op must rise exactly on the HOLD+1 th quiet edge
  task automatic check_idle();
    for (int k = 1; k <= `BIU_IDLE_HOLD + 1; k++) begin
      @(posedge coreclk);
      @(negedge coreclk);
      check_val("biu_no_op", biu_no_op, k == `BIU_IDLE_HOLD + 1);
    end
    advance();
  endtask

  task automatic run_read(input vec_t v);
    rd_req_t ifu_x;
    rd_req_t lsu_x;
    rd_req_t exp_ar;
    rd_req_t sent[$];
    logic    to_ifu[$];
    logic    pick_b;
    ifu_x      = rand_rd();
    lsu_x      = rand_rd();
    lsu_x.id   = v.id;
    ifu_rd     = ifu_x;
    lsu_ar     = lsu_x;
    ifu_rd_req = v.req_a;
    lsu_ar_req = v.req_b;
    for (int i = 0; i < v.req_a + v.req_b; i++) begin
      pick_b = (i == 0) ? v.first_b : !v.first_b;
      wait_grant(1'b1);
      check_val("lsu_ar_grnt", lsu_ar_grnt, pick_b);
      check_val("ifu_rd_grnt", ifu_rd_grnt, !pick_b);
      exp_ar = pick_b ? lsu_x : ifu_x;
      if (!pick_b) begin
        exp_ar.id = `BIU_IFU_ID;
      end
      sent.push_back(exp_ar);
      to_ifu.push_back(!pick_b);
      issue_ar(exp_ar, !pick_b, v.dly_a);
    end
    foreach (sent[i]) begin
      return_beat(sent[i].id, v.hold, to_ifu[i]);
    end
    check_idle();
  endtask

  task automatic run_write(input vec_t v);
    wr_req_t st_x;
    wr_req_t vict_x;
    wr_req_t exp_wr;
    b_resp_t bb;
    logic    pick_b;
    int      kmax;
    st_x     = rand_wr();
    vict_x   = rand_wr();
    st       = st_x;
    vict     = vict_x;
    st_req   = v.req_a;
    vict_req = v.req_b;
    kmax     = (v.dly_a > v.dly_b) ? v.dly_a : v.dly_b;
    for (int i = 0; i < v.req_a + v.req_b; i++) begin
      pick_b = (i == 0) ? v.first_b : !v.first_b;
      wait_grant(1'b0);
      check_val("vict_grnt", vict_grnt, pick_b);
      check_val("st_grnt", st_grnt, !pick_b);
      exp_wr = pick_b ? vict_x : st_x;
      advance();
      if (pick_b) begin
        vict_req = 1'b0;
      end else begin
        st_req = 1'b0;
      end
      for (int k = 0; k <= kmax; k++) begin
        pad_awready = (k == v.dly_a);
        pad_wready  = (k == v.dly_b);
        @(negedge coreclk);
        check_val("pad_awvalid", pad_awvalid, k <= v.dly_a);
        check_val("pad_wvalid", pad_wvalid, k <= v.dly_b);
        check_val("pad_wr", pad_wr, exp_wr);
        check_val("vict_grnt", vict_grnt, 1'b0);
        check_val("st_grnt", st_grnt, 1'b0);
        advance();
      end
      pad_awready = 1'b0;
      pad_wready  = 1'b0;
    end
    for (int i = 0; i < v.req_a + v.req_b; i++) begin
      bb.id      = v.id + i[`BIU_ID_W-1:0];
      bb.resp    = v.resp;
      pad_b      = bb;
      pad_bvalid = 1'b1;
      @(negedge coreclk);
      check_val("lsu_b_vld", lsu_b_vld, 1'b1);
      check_val("lsu_b", lsu_b, bb);
      check_val("pad_awvalid", pad_awvalid, 1'b0);
      check_val("pad_wvalid", pad_wvalid, 1'b0);
      check_val("biu_no_op", biu_no_op, 1'b0);
      advance();
      pad_bvalid = 1'b0;
    end
    check_idle();
  endtask

  task automatic run_limit(input vec_t v);
    rd_req_t req;
    for (int i = 0; i <= `BIU_MAX_OUTSTANDING; i++) begin
      req        = rand_rd();
      req.id     = v.id;
      lsu_ar     = req;
      lsu_ar_req = 1'b1;
      if (i == `BIU_MAX_OUTSTANDING) begin
        // Channel is full, so the request waits for a last beat
        repeat (4) begin
          @(negedge coreclk);
          check_val("lsu_ar_grnt", lsu_ar_grnt, 1'b0);
          advance();
        end
        return_beat(v.id, v.hold, 1'b0);
      end
      wait_grant(1'b1);
      check_val("lsu_ar_grnt", lsu_ar_grnt, 1'b1);
      issue_ar(req, 1'b0, v.dly_a);
    end
    repeat (`BIU_MAX_OUTSTANDING) begin
      return_beat(v.id, v.hold, 1'b0);
    end
    check_idle();
  endtask

  initial begin
    #((NUM_VEC * 200 + 10) * CLK_NS);
    $display("Watchdog expired before the test sequence finished");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    seed        = 54;
    val_errs    = 0;
    hs_errs     = 0;
    rst_n       = 1'b0;
    ifu_rd_req  = 1'b0;
    ifu_rd      = '0;
    lsu_ar_req  = 1'b0;
    lsu_ar      = '0;
    pad_arready = 1'b0;
    pad_rvalid  = 1'b0;
    pad_r       = '0;
    ifu_r_ready = 1'b0;
    lsu_r_ready = 1'b0;
    st_req      = 1'b0;
    st          = '0;
    vict_req    = 1'b0;
    vict        = '0;
    pad_awready = 1'b0;
    pad_wready  = 1'b0;
    pad_bvalid  = 1'b0;
    pad_b       = '0;
    // kind, a, b, first_b, id, resp, dly_a, dly_b, hold
    vecs[0] = '{2'd0, 1'b1, 1'b1, 1'b1, 5'h03, 2'd0, 4'd2, 4'd0, 4'd1};
    vecs[1] = '{2'd0, 1'b1, 1'b0, 1'b0, 5'h00, 2'd0, 4'd0, 4'd0, 4'd0};
    vecs[2] = '{2'd1, 1'b1, 1'b1, 1'b1, 5'h07, 2'd2, 4'd0, 4'd3, 4'd0};
    vecs[3] = '{2'd1, 1'b1, 1'b0, 1'b0, 5'h0a, 2'd1, 4'd2, 4'd0, 4'd0};
    vecs[4] = '{2'd2, 1'b0, 1'b1, 1'b1, 5'h04, 2'd0, 4'd0, 4'd0, 4'd1};
    vecs[5] = '{2'd0, 1'b0, 1'b1, 1'b1, 5'h11, 2'd0, 4'd1, 4'd0, 4'd2};
    repeat (2) @(posedge coreclk);
    #1 rst_n = 1'b1;
    check_idle();
    foreach (vecs[i]) begin
      case (vecs[i].kind)
        2'd0:    run_read(vecs[i]);
        2'd1:    run_write(vecs[i]);
        default: run_limit(vecs[i]);
      endcase
    end
    $display("Errors: %0d value, %0d handshake", val_errs, hs_errs);
    if (val_errs + hs_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+hw
hw/biu_pkg.sv
hw/biu_read_channel.sv
hw/biu_write_channel.sv
hw/biu_idle_monitor.sv
hw/biu_top.sv
verification/biu_tb.sv

/* Bender.yml */
package:
  name: biu

sources:
  - include_dirs:
      - hw
    files:
      - hw/biu_pkg.sv
      - hw/biu_read_channel.sv
      - hw/biu_write_channel.sv
      - hw/biu_idle_monitor.sv
      - hw/biu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/biu_tb.sv
